// ==== hw/y86_defines.svh ====
`ifndef Y86_DEFINES_SVH
`define Y86_DEFINES_SVH

// instruction memory geometry
`define IMEM_BYTES 2048
`define IMEM_AW    11

// apb register map, above the memory bytes
`define REG_CTRL   12'h800
`define REG_STATUS 12'h804
`define REG_PC     12'h808

// icode/ifun byte plus register byte plus 8 byte constant
`define MAX_ILEN   10

`endif

// ==== hw/y86_pkg.sv ====
package y86_pkg;

	typedef enum logic [3:0] {
		HALT   = 4'h0,
		NOP    = 4'h1,
		RRMOVQ = 4'h2, // also cmovXX
		IRMOVQ = 4'h3,
		RMMOVQ = 4'h4,
		MRMOVQ = 4'h5,
		OPQ    = 4'h6,
		JXX    = 4'h7,
		CALL   = 4'h8,
		RET    = 4'h9,
		PUSHQ  = 4'hA,
		POPQ   = 4'hB
	} icode_e;

	// y86 status, packed into two bits
	typedef enum logic [1:0] {
		AOK = 2'd0,
		HLT = 2'd1,
		ADR = 2'd2,
		INS = 2'd3
	} stat_e;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		RUN    = 2'd1,
		HALTED = 2'd2,
		FAULT  = 2'd3
	} run_state_e;

endpackage

// ==== hw/instruction_memory.sv ====
`include "y86_defines.svh"

module instruction_memory (
	input  logic                         clk,
	input  logic                         we,
	input  logic [`IMEM_AW-1:0]          waddr,
	input  logic [7:0]                   wdata,
	input  logic [`IMEM_AW-1:0]          raddr,
	output logic [7:0]                   rdata,
	input  logic [63:0]                  pc,
	output logic [7:0]                   byte0,
	output logic [8*(`MAX_ILEN-1)-1:0]   bytes19,
	output logic                         imem_error
);

	logic [7:0] mem [`IMEM_BYTES];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr]; // apb readback

	assign imem_error = pc > 64'(`IMEM_BYTES - 1);

	// byte 1 lands in the top of bytes19, byte 9 in the bottom
	always_comb begin
		logic [63:0] addr;
		addr = '0;
		byte0 = 8'h00;
		bytes19 = '0;
		if (!imem_error) begin
			byte0 = mem[pc[`IMEM_AW-1:0]];
			for (int i = 1; i < `MAX_ILEN; i++) begin
				addr = pc + 64'(i);
				if (addr < 64'(`IMEM_BYTES)) // past the end reads zero
					bytes19[8*(`MAX_ILEN-1-i) +: 8] = mem[addr[`IMEM_AW-1:0]];
			end
		end
	end

endmodule

// ==== hw/fetch_decode.sv ====
module fetch_decode (
	input  logic [63:0]     pc,
	input  logic [7:0]      byte0,
	input  logic [71:0]     bytes19,
	input  logic            imem_error,
	output y86_pkg::icode_e icode,
	output logic [3:0]      ifun,
	output logic [3:0]      ra,
	output logic [3:0]      rb,
	output logic [63:0]     valc,
	output logic [63:0]     valp,
	output y86_pkg::stat_e  stat
);
	import y86_pkg::*;

	logic [3:0]  icode_raw;
	logic        need_regids;
	logic        need_valc;
	logic        ifun_ok;
	logic [63:0] cwin;

	assign icode_raw = byte0[7:4];
	assign icode = icode_e'(icode_raw);
	assign ifun = byte0[3:0];

	always_comb begin
		need_regids = 1'b0;
		need_valc = 1'b0;
		case (icode_raw)
			RRMOVQ, OPQ, PUSHQ, POPQ: need_regids = 1'b1;
			IRMOVQ, RMMOVQ, MRMOVQ: begin
				need_regids = 1'b1;
				need_valc = 1'b1;
			end
			JXX, CALL: need_valc = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		case (icode_raw)
			OPQ:         ifun_ok = ifun <= 4'd3;
			JXX, RRMOVQ: ifun_ok = ifun <= 4'd6; // conditions 0..6
			default:     ifun_ok = ifun == 4'd0;
		endcase
	end

	// no register byte, report rnone
	assign ra = need_regids ? bytes19[71:68] : 4'hF;
	assign rb = need_regids ? bytes19[67:64] : 4'hF;

	assign cwin = need_regids ? bytes19[63:0] : bytes19[71:8];

	// little endian, first window byte is the lsb
	always_comb begin
		valc = '0;
		if (need_valc) begin
			for (int k = 0; k < 8; k++)
				valc[8*k +: 8] = cwin[8*(7-k) +: 8];
		end
	end

	assign valp = pc + 64'd1 + (need_regids ? 64'd1 : 64'd0) + (need_valc ? 64'd8 : 64'd0);

	always_comb begin
		if (imem_error)
			stat = ADR;
		else if (icode_raw > POPQ || !ifun_ok)
			stat = INS;
		else if (icode_raw == HALT)
			stat = HLT;
		else
			stat = AOK;
	end

endmodule

// ==== hw/fetch_sequencer.sv ====
`include "y86_defines.svh"

module fetch_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  logic [`IMEM_AW-1:0] start_pc,
	input  y86_pkg::stat_e      stat,
	input  logic [63:0]         valp,
	output logic [63:0]         pc,
	output y86_pkg::run_state_e run_state,
	output y86_pkg::stat_e      last_stat,
	output logic [15:0]         fetch_count,
	output logic                fetch_valid
);
	import y86_pkg::*;

	run_state_e state;
	run_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		if (start)
			state_nxt = RUN; // also the restart path from HALTED/FAULT
		else if (state == RUN) begin
			case (stat)
				HLT:      state_nxt = HALTED;
				ADR, INS: state_nxt = FAULT;
				default:  ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			pc <= '0;
			last_stat <= AOK;
			fetch_count <= '0;
		end else begin
			state <= state_nxt;
			if (start) begin
				pc <= 64'(start_pc);
				last_stat <= AOK;
				fetch_count <= '0;
			end else if (state == RUN) begin
				last_stat <= stat;
				fetch_count <= fetch_count + 16'd1; // terminal fetch counts too
				if (stat == AOK)
					pc <= valp; // branch targets not followed
			end
		end
	end

	assign run_state = state;

	// one fetch per cycle while running
	assign fetch_valid = state == RUN;

endmodule

// ==== hw/imem_apb_port.sv ====
`include "y86_defines.svh"

module imem_apb_port (
	input  logic                clk,
	input  logic                rst,
	input  logic [11:0]         paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	input  y86_pkg::run_state_e run_state,
	input  y86_pkg::stat_e      last_stat,
	input  logic [15:0]         fetch_count,
	input  logic [31:0]         pc,
	output logic                mem_we,
	output logic [`IMEM_AW-1:0] mem_waddr,
	output logic [7:0]          mem_wdata,
	output logic [`IMEM_AW-1:0] mem_raddr,
	input  logic [7:0]          mem_rdata,
	output logic                start,
	output logic [`IMEM_AW-1:0] start_pc
);
	import y86_pkg::*;

	logic setup;
	logic access;
	logic is_mem;
	logic is_ctrl;
	logic wr_err;
	logic wr_ok;
	logic ready_q;
	logic err_q;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign is_mem = paddr < 12'(`IMEM_BYTES);
	assign is_ctrl = paddr == `REG_CTRL;

	// busy, read only or unmapped
	assign wr_err = pwrite && (run_state == RUN || (!is_mem && !is_ctrl));

	// response formed in setup, presented in the access cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ready_q <= setup;
			err_q <= setup && wr_err;
		end
	end

	assign pready = ready_q;
	assign pslverr = err_q;
	assign wr_ok = access && pwrite && !err_q;

	assign mem_we = wr_ok && is_mem;
	assign mem_waddr = paddr[`IMEM_AW-1:0];
	assign mem_wdata = pwdata[7:0];
	assign mem_raddr = paddr[`IMEM_AW-1:0];
	assign start = wr_ok && is_ctrl;
	assign start_pc = pwdata[`IMEM_AW-1:0];

	always_comb begin
		if (is_mem)
			prdata = {24'h000000, mem_rdata};
		else begin
			case (paddr)
				`REG_STATUS: prdata = {fetch_count, 12'h000, last_stat, run_state};
				`REG_PC:     prdata = pc;
				default:     prdata = '0; // ctrl reads back zero
			endcase
		end
	end

endmodule

// ==== hw/y86_fetch_top.sv ====
`include "y86_defines.svh"

module y86_fetch_top (
	input  logic            clk,
	input  logic            rst,
	input  logic [11:0]     paddr,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  logic [31:0]     pwdata,
	output logic [31:0]     prdata,
	output logic            pready,
	output logic            pslverr,
	output logic            fetch_valid,
	output logic [63:0]     fetch_pc,
	output y86_pkg::icode_e fetch_icode,
	output logic [3:0]      fetch_ifun,
	output logic [3:0]      fetch_ra,
	output logic [3:0]      fetch_rb,
	output logic [63:0]     fetch_valc,
	output y86_pkg::stat_e  fetch_stat
);
	import y86_pkg::*;

	logic                       mem_we;
	logic [`IMEM_AW-1:0]        mem_waddr;
	logic [7:0]                 mem_wdata;
	logic [`IMEM_AW-1:0]        mem_raddr;
	logic [7:0]                 mem_rdata;
	logic                       start;
	logic [`IMEM_AW-1:0]        start_pc;
	run_state_e                 run_state;
	stat_e                      last_stat;
	logic [15:0]                fetch_count;
	logic [7:0]                 byte0;
	logic [8*(`MAX_ILEN-1)-1:0] bytes19;
	logic                       imem_error;
	logic [63:0]                valp;

	imem_apb_port u_apb (
		.clk(clk), .rst(rst),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.run_state(run_state), .last_stat(last_stat), .fetch_count(fetch_count),
		.pc(fetch_pc[31:0]),
		.mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
		.mem_raddr(mem_raddr), .mem_rdata(mem_rdata),
		.start(start), .start_pc(start_pc)
	);

	instruction_memory u_imem (
		.clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
		.raddr(mem_raddr), .rdata(mem_rdata),
		.pc(fetch_pc), .byte0(byte0), .bytes19(bytes19), .imem_error(imem_error)
	);

	// trace fields come straight from decode
	fetch_decode u_dec (
		.pc(fetch_pc), .byte0(byte0), .bytes19(bytes19), .imem_error(imem_error),
		.icode(fetch_icode), .ifun(fetch_ifun), .ra(fetch_ra), .rb(fetch_rb),
		.valc(fetch_valc), .valp(valp), .stat(fetch_stat)
	);

	fetch_sequencer u_seq (
		.clk(clk), .rst(rst),
		.start(start), .start_pc(start_pc), .stat(fetch_stat), .valp(valp),
		.pc(fetch_pc), .run_state(run_state), .last_stat(last_stat),
		.fetch_count(fetch_count), .fetch_valid(fetch_valid)
	);

endmodule

// ==== testbench/y86_fetch_asserts.sv ====
module y86_fetch_asserts (
	input logic                clk,
	input logic                rst,
	input logic                psel,
	input logic                penable,
	input logic                pready,
	input logic                start,
	input logic                fetch_valid,
	input logic [63:0]         fetch_pc,
	input y86_pkg::stat_e      fetch_stat,
	input y86_pkg::run_state_e run_state
);
	timeunit 1ns;
	timeprecision 100ps;
	import y86_pkg::*;

	int err_count = 0;

	pready_in_access: assert property (@(posedge clk) disable iff (rst)
		pready |-> psel && penable)
		else begin
			err_count++;
			$error("pready high outside an apb access cycle");
		end

	// running means just started, or the previous fetch was AOK
	valid_only_running: assert property (@(posedge clk) disable iff (rst)
		fetch_valid |-> $past(start) || $past(fetch_valid && fetch_stat == AOK))
		else begin
			err_count++;
			$error("fetch_valid high while not running");
		end

	// a stopped sequencer keeps its pc until restarted
	pc_held_when_stopped: assert property (@(posedge clk) disable iff (rst)
		(run_state inside {HALTED, FAULT}) && $past(run_state inside {HALTED, FAULT})
		|-> $stable(fetch_pc))
		else begin
			err_count++;
			$error("pc moved while halted or faulted");
		end

endmodule

bind y86_fetch_top y86_fetch_asserts u_chk (
	.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
	.start(start), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
	.fetch_stat(fetch_stat), .run_state(run_state)
);

// ==== testbench/y86_fetch_tb.sv ====
`include "y86_defines.svh"

module y86_fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import y86_pkg::*;

	typedef struct packed {
		logic [63:0] pc;
		logic [3:0]  icode;
		logic [3:0]  ifun;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [63:0] valc;
		stat_e       stat;
		logic        fields; // icode through valc compared
		logic        regs;
	} trace_t;

	// apb traffic of all tests, with margin, plus reset
	localparam int LIMIT = 2 * (3 * (2 * 64 + 100 + 30) + 60) + 16;

	logic        clk;
	logic        rst;
	logic [11:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        fetch_valid;
	logic [63:0] fetch_pc;
	icode_e      fetch_icode;
	logic [3:0]  fetch_ifun;
	logic [3:0]  fetch_ra;
	logic [3:0]  fetch_rb;
	logic [63:0] fetch_valc;
	stat_e       fetch_stat;

	trace_t      exp_q[$];
	logic [11:0] img_addr[$];
	logic [7:0]  img_data[$];
	logic [63:0] prog_pc;
	logic [63:0] last_pc;
	int          run_len;
	int          cycles = 0;
	integer      seed = 19;

	y86_fetch_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(input logic ok, input string what);
		assert (ok) else begin
			$display("FAIL at %0t ns: %s", $time, what);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#1;
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		rdata = prdata;
		err = pslverr;
		@(posedge clk); // write lands here
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	function automatic stat_e expected_stat(input logic [3:0] icode, input logic [3:0] ifun);
		logic [3:0] ifun_max;
		case (icode)
			4'h6:       ifun_max = 4'd3;
			4'h2, 4'h7: ifun_max = 4'd6;
			default:    ifun_max = 4'd0;
		endcase
		if (icode > 4'hB || ifun > ifun_max)
			return INS;
		if (icode == 4'h0)
			return HLT;
		return AOK;
	endfunction

	task automatic put_byte(input logic [7:0] d);
		img_addr.push_back(prog_pc[11:0]);
		img_data.push_back(d);
		prog_pc = prog_pc + 64'd1;
	endtask

	// encodes one instruction at prog_pc and queues its trace entry
	task automatic add_instr(input logic [3:0] icode, input logic [3:0] ifun,
			input logic [3:0] ra, input logic [3:0] rb, input logic [63:0] valc);
		trace_t e;
		logic regs;
		logic cst;
		regs = icode inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hA, 4'hB};
		cst = icode inside {4'h3, 4'h4, 4'h5, 4'h7, 4'h8};
		e.pc = prog_pc;
		e.icode = icode;
		e.ifun = ifun;
		e.ra = ra;
		e.rb = rb;
		e.valc = cst ? valc : 64'd0;
		e.stat = expected_stat(icode, ifun);
		e.fields = 1'b1;
		e.regs = regs;
		exp_q.push_back(e);
		put_byte({icode, ifun});
		if (regs)
			put_byte({ra, rb});
		if (cst) begin
			for (int k = 0; k < 8; k++)
				put_byte(valc[8*k +: 8]);
		end
	endtask

	task automatic expect_adr();
		trace_t e;
		e = '0;
		e.pc = prog_pc;
		e.stat = ADR;
		exp_q.push_back(e);
	endtask

	task automatic start_program(input logic [11:0] start);
		logic [31:0] rd;
		logic err;
		while (img_addr.size() != 0) begin
			apb_xfer(1'b1, img_addr.pop_front(), 32'(img_data.pop_front()), rd, err);
			check(!err, "pslverr on program load");
		end
		run_len = exp_q.size();
		last_pc = exp_q[exp_q.size() - 1].pc;
		apb_xfer(1'b1, `REG_CTRL, 32'(start), rd, err);
		check(!err, "pslverr on run start");
	endtask

	task automatic finish_program(input run_state_e exp_state, input stat_e exp_stat);
		logic [31:0] rd;
		logic err;
		do
			apb_xfer(1'b0, `REG_STATUS, 32'd0, rd, err);
		while (rd[1:0] == 2'(RUN));
		check(exp_q.size() == 0, "run stopped before every expected fetch");
		check(rd[1:0] == 2'(exp_state), $sformatf("state %0d, expected %0d", rd[1:0], exp_state));
		check(rd[3:2] == 2'(exp_stat), $sformatf("status %0d, expected %0d", rd[3:2], exp_stat));
		check(rd[31:16] == 16'(run_len), $sformatf("count %0d, expected %0d", rd[31:16], run_len));
		apb_xfer(1'b0, `REG_PC, 32'd0, rd, err);
		check(rd == last_pc[31:0], $sformatf("pc reg %0h, expected %0h", rd, last_pc[31:0]));
	endtask

	initial begin : trace_monitor
		trace_t e;
		forever begin
			@(negedge clk);
			if (fetch_valid === 1'b1) begin
				check(exp_q.size() != 0, "fetch reported with no instruction expected");
				e = exp_q.pop_front();
				check(fetch_pc == e.pc, $sformatf("pc %0h, expected %0h", fetch_pc, e.pc));
				check(fetch_stat == e.stat,
					$sformatf("stat %0d at %0h, expected %0d", fetch_stat, e.pc, e.stat));
				if (e.fields) begin
					check(4'(fetch_icode) == e.icode && fetch_ifun == e.ifun,
						$sformatf("icode/ifun %0h/%0h at %0h", fetch_icode, fetch_ifun, e.pc));
					check(fetch_valc == e.valc,
						$sformatf("valc %0h, expected %0h", fetch_valc, e.valc));
					if (e.regs)
						check(fetch_ra == e.ra && fetch_rb == e.rb,
							$sformatf("ra/rb %0h/%0h at %0h", fetch_ra, fetch_rb, e.pc));
				end
			end
		end
	end

	initial begin : watchdog
		forever begin
			@(posedge clk);
			cycles++;
			if (DUT.u_chk.err_count != 0) begin
				$display("a bound assertion on the fetch top level failed");
				$display("Something failed");
				$fatal(1);
			end else if (cycles > LIMIT) begin
				$display("timeout, the tests did not finish within %0d cycles", LIMIT);
				$display("Something failed");
				$fatal(1);
			end
		end
	end

	initial begin : main
		logic [31:0] rd;
		logic        err;
		logic [7:0]  shadow [64];
		rst = 1'b1;
		paddr = 12'h000;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'd0;
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < 64; i++) begin
			shadow[i] = 8'($random(seed));
			apb_xfer(1'b1, 12'h700 + 12'(i), 32'(shadow[i]), rd, err);
			check(!err, "pslverr on memory write");
		end
		for (int i = 0; i < 64; i++) begin
			apb_xfer(1'b0, 12'h700 + 12'(i), 32'd0, rd, err);
			check(rd == {24'h000000, shadow[i]} && !err,
				$sformatf("byte %0d read %0h, expected %0h", i, rd, shadow[i]));
		end

		prog_pc = 64'h000;
		add_instr(IRMOVQ, 4'd0, 4'hF, 4'h0, 64'h0123_4567_89ab_cdef);
		add_instr(RRMOVQ, 4'd0, 4'h0, 4'h3, 64'd0);
		add_instr(OPQ, 4'd0, 4'h0, 4'h3, 64'd0);
		add_instr(JXX, 4'd4, 4'hF, 4'hF, 64'h40); // jne, target not followed
		add_instr(CALL, 4'd0, 4'hF, 4'hF, 64'h80);
		add_instr(PUSHQ, 4'd0, 4'h0, 4'hF, 64'd0);
		add_instr(POPQ, 4'd0, 4'h3, 4'hF, 64'd0);
		add_instr(NOP, 4'd0, 4'hF, 4'hF, 64'd0);
		add_instr(RET, 4'd0, 4'hF, 4'hF, 64'd0);
		add_instr(HALT, 4'd0, 4'hF, 4'hF, 64'd0);
		start_program(12'h000);
		finish_program(HALTED, HLT);

		prog_pc = 64'h100;
		add_instr(NOP, 4'd0, 4'hF, 4'hF, 64'd0);
		add_instr(OPQ, 4'd7, 4'h0, 4'h1, 64'd0);
		start_program(12'h100);
		finish_program(FAULT, INS);
		prog_pc = 64'h120;
		add_instr(4'hC, 4'd0, 4'hF, 4'hF, 64'd0);
		start_program(12'h120);
		finish_program(FAULT, INS);

		// two nops at the top of memory, then off the end
		prog_pc = 64'd2046;
		add_instr(NOP, 4'd0, 4'hF, 4'hF, 64'd0);
		add_instr(NOP, 4'd0, 4'hF, 4'hF, 64'd0);
		expect_adr();
		start_program(12'h7FE);
		finish_program(FAULT, ADR);

		prog_pc = 64'h200;
		repeat (40) add_instr(NOP, 4'd0, 4'hF, 4'hF, 64'd0);
		add_instr(HALT, 4'd0, 4'hF, 4'hF, 64'd0);
		start_program(12'h200);
		apb_xfer(1'b1, 12'h705, 32'(~shadow[5]), rd, err);
		check(err === 1'b1, "memory write during a run was accepted");
		finish_program(HALTED, HLT);
		apb_xfer(1'b0, 12'h705, 32'd0, rd, err);
		check(rd[7:0] == shadow[5], $sformatf("busy write changed byte to %0h", rd[7:0]));

		if (DUT.u_chk.err_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

// ==== sim.f ====
+incdir+hw
hw/y86_pkg.sv
hw/instruction_memory.sv
hw/fetch_decode.sv
hw/fetch_sequencer.sv
hw/imem_apb_port.sv
hw/y86_fetch_top.sv
testbench/y86_fetch_asserts.sv
testbench/y86_fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the fetch stage testbench with verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module y86_fetch_tb -f sim.f; then
	echo "verilator build failed"
	exit 1
fi

# keep running past a bound assertion so the testbench can report it
out=$(./obj_dir/Vy86_fetch_tb +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -qx "Everything OK" <<< "$out"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
